// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address word width
`define CPU_XLEN 32

// Register number width, 32 architectural registers
`define CPU_REG_AW 5

// I-type immediate field, sign-extended
`define CPU_IMM_W 17

// JI-type target field, zero-extended
`define CPU_TGT_W 27

// Register written by jal
`define CPU_LINK_REG 31

// First fetch address out of reset
`define CPU_RESET_PC 0

`endif

// File: src/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

  // One data or address word
  typedef logic [`CPU_XLEN-1:0] word_t;

  // One register number
  typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

  // Major opcode, instruction bits 31:27
  typedef enum logic [4:0] {
    OP_ALU  = 5'd0,
    OP_J    = 5'd1,
    OP_BNE  = 5'd2,
    OP_JAL  = 5'd3,
    OP_JR   = 5'd4,
    OP_ADDI = 5'd5,
    OP_BLT  = 5'd6,
    OP_SW   = 5'd7,
    OP_LW   = 5'd8
  } opcode_e;

  // R-type function field, instruction bits 6:2
  typedef enum logic [4:0] {
    ADD = 5'd0,
    SUB = 5'd1,
    AND = 5'd2,
    OR  = 5'd3,
    SLL = 5'd4,
    SRA = 5'd5
  } alu_op_e;

endpackage

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package pipe_pkg;

  import isa_pkg::*;

  // Fetch to decode
  // An all-zero instruction decodes as add r0 and writes nothing
  typedef struct packed {
    word_t instr;
    word_t pc_plus1;
  } fd_t;

  // Decode to execute
  // rs and rt hold the register-file read numbers, not the raw fields
  typedef struct packed {
    opcode_e   opcode;
    alu_op_e   alu_op;
    reg_addr_t shamt;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     imm;
    word_t     pc_plus1;
    word_t     target;
    logic      we;
  } dx_t;

  // Execute to memory
  // For sw, rd names the stored register
  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rd;
    logic      we;
    word_t     result;
    word_t     store_data;
    word_t     pc_plus1;
  } xm_t;

  // Memory to writeback
  typedef struct packed {
    reg_addr_t rd;
    logic      we;
    logic      is_load;
    logic      is_jal;
    word_t     result;
    word_t     load_data;
    word_t     pc_plus1;
  } mw_t;

  // Taken branch or jump out of execute
  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module fetch_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  input  logic      stall,
  input  redirect_t redirect,
  input  word_t     q_imem,
  output word_t     address_imem,
  output fd_t       fd
);

  word_t pc;
  word_t pc_plus1;
  word_t pc_next;

  // Word addressed, so the next sequential fetch is one up
  assign pc_plus1 = pc + word_t'(1);
  assign address_imem = pc;

  // Redirect wins over the load-use hold
  always_comb begin
    if (redirect.taken) begin
      pc_next = redirect.target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc_plus1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= word_t'(`CPU_RESET_PC);
    end else begin
      pc <= pc_next;
    end
  end

  // Fetched word is squashed when an older branch or jump resolves taken
  always_ff @(posedge clock) begin
    if (!rst_n || redirect.taken) begin
      fd <= '0;
    end else if (!stall) begin
      fd.instr    <= q_imem;
      fd.pc_plus1 <= pc_plus1;
    end
  end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  input  logic      stall,
  input  redirect_t redirect,
  input  fd_t       fd,
  input  word_t     data_readRegA,
  input  word_t     data_readRegB,
  output reg_addr_t ctrl_readRegA,
  output reg_addr_t ctrl_readRegB,
  output logic      uses_rt,
  output dx_t       dx
);

  opcode_e   opcode;
  reg_addr_t f_rd;
  reg_addr_t f_rs;
  reg_addr_t f_rt;
  reg_addr_t dest;
  logic      is_branch;
  logic      writes;
  word_t     imm_ext;
  word_t     target_ext;

  // Instruction fields
  assign opcode = opcode_e'(fd.instr[31:27]);
  assign f_rd   = fd.instr[26:22];
  assign f_rs   = fd.instr[21:17];
  assign f_rt   = fd.instr[16:12];

  assign is_branch = (opcode == OP_BNE) || (opcode == OP_BLT);

  // Branches compare rd against rs, so rd goes out on port A
  assign ctrl_readRegA = is_branch ? f_rd : f_rs;

  // Port B carries rs for branches and rd for sw data and jr target
  always_comb begin
    if (is_branch) begin
      ctrl_readRegB = f_rs;
    end else if ((opcode == OP_SW) || (opcode == OP_JR)) begin
      ctrl_readRegB = f_rd;
    end else begin
      ctrl_readRegB = f_rt;
    end
  end

  // Port B is a true source only here
  // sw data is patched later in the memory stage
  assign uses_rt = (opcode == OP_ALU) || is_branch || (opcode == OP_JR);

  // jal links into the fixed register
  assign dest = (opcode == OP_JAL) ? reg_addr_t'(`CPU_LINK_REG) : f_rd;

  assign writes = (opcode == OP_ALU) || (opcode == OP_ADDI) ||
                  (opcode == OP_LW) || (opcode == OP_JAL);

  assign imm_ext = {{(`CPU_XLEN - `CPU_IMM_W){fd.instr[`CPU_IMM_W-1]}},
                    fd.instr[`CPU_IMM_W-1:0]};
  assign target_ext = {{(`CPU_XLEN - `CPU_TGT_W){1'b0}}, fd.instr[`CPU_TGT_W-1:0]};

  // Bubble on load-use stall or flush
  always_ff @(posedge clock) begin
    if (!rst_n || stall || redirect.taken) begin
      dx <= '0;
    end else begin
      dx.opcode   <= opcode;
      dx.alu_op   <= alu_op_e'(fd.instr[6:2]);
      dx.shamt    <= fd.instr[11:7];
      dx.rs       <= ctrl_readRegA;
      dx.rt       <= ctrl_readRegB;
      dx.rd       <= dest;
      dx.a        <= data_readRegA;
      dx.b        <= data_readRegB;
      dx.imm      <= imm_ext;
      dx.pc_plus1 <= fd.pc_plus1;
      dx.target   <= target_ext;
      // r0 is never a real destination
      dx.we       <= writes && (dest != '0);
    end
  end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module alu
  import isa_pkg::*;
(
  input  word_t     operand_a,
  input  word_t     operand_b,
  input  alu_op_e   op,
  input  reg_addr_t shamt,
  output word_t     result,
  output logic      not_equal,
  output logic      less_than
);

  word_t diff;

  // Shared subtractor for SUB and the compare flags
  assign diff = operand_a - operand_b;

  always_comb begin
    case (op)
      ADD:     result = operand_a + operand_b;
      SUB:     result = diff;
      AND:     result = operand_a & operand_b;
      OR:      result = operand_a | operand_b;
      SLL:     result = operand_a << shamt;
      SRA:     result = word_t'($signed(operand_a) >>> shamt);
      default: result = '0;
    endcase
  end

  assign not_equal = |diff;

  // Signed A < B
  // with differing signs the difference may overflow, so A's sign decides
  assign less_than = (operand_a[`CPU_XLEN-1] ^ operand_b[`CPU_XLEN-1]) ?
                     operand_a[`CPU_XLEN-1] : diff[`CPU_XLEN-1];

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execute_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  input  dx_t       dx,
  input  fwd_sel_e  fwd_a,
  input  fwd_sel_e  fwd_b,
  input  word_t     mem_result,
  input  word_t     wb_result,
  output redirect_t redirect,
  output xm_t       xm
);

  word_t   a_fwd;
  word_t   b_fwd;
  word_t   op_b;
  word_t   alu_result;
  word_t   branch_target;
  alu_op_e op;
  logic    not_equal;
  logic    less_than;
  logic    is_branch;
  logic    uses_imm;
  logic    br_taken;

  // Bypass mux, memory result is the younger of the two
  function automatic word_t pick(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                 word_t wb_val);
    case (sel)
      FWD_MEM: pick = mem_val;
      FWD_WB:  pick = wb_val;
      default: pick = reg_val;
    endcase
  endfunction

  assign a_fwd = pick(fwd_a, dx.a, mem_result, wb_result);
  assign b_fwd = pick(fwd_b, dx.b, mem_result, wb_result);

  assign is_branch = (dx.opcode == OP_BNE) || (dx.opcode == OP_BLT);
  assign uses_imm  = (dx.opcode == OP_ADDI) || (dx.opcode == OP_LW) ||
                     (dx.opcode == OP_SW);

  assign op_b = uses_imm ? dx.imm : b_fwd;

  // Function field is only meaningful for R-type
  always_comb begin
    if (is_branch) begin
      op = SUB;
    end else if (uses_imm) begin
      op = ADD;
    end else begin
      op = dx.alu_op;
    end
  end

  alu u_alu (
    .operand_a (a_fwd),
    .operand_b (op_b),
    .op        (op),
    .shamt     (dx.shamt),
    .result    (alu_result),
    .not_equal (not_equal),
    .less_than (less_than)
  );

  assign branch_target = dx.pc_plus1 + dx.imm;
  assign br_taken = ((dx.opcode == OP_BNE) && not_equal) ||
                    ((dx.opcode == OP_BLT) && less_than);

  // Resolve control flow here; fetch and decode flush on taken
  always_comb begin
    redirect.taken = br_taken || (dx.opcode == OP_J) || (dx.opcode == OP_JAL) ||
                     (dx.opcode == OP_JR);
    if (is_branch) begin
      redirect.target = branch_target;
    end else if (dx.opcode == OP_JR) begin
      // jr target came in on port B
      redirect.target = b_fwd;
    end else begin
      redirect.target = dx.target;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      xm <= '0;
    end else begin
      xm.opcode     <= dx.opcode;
      xm.rd         <= dx.rd;
      xm.we         <= dx.we;
      xm.result     <= alu_result;
      xm.store_data <= b_fwd;
      xm.pc_plus1   <= dx.pc_plus1;
    end
  end

endmodule

`default_nettype wire

// File: src/memory_writeback.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module memory_writeback
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  input  xm_t       xm,
  input  word_t     q_dmem,
  output word_t     address_dmem,
  output word_t     data,
  output logic      wren,
  output word_t     mem_result,
  output reg_addr_t mem_rd,
  output logic      mem_we,
  output logic      ctrl_writeEnable,
  output reg_addr_t ctrl_writeReg,
  output word_t     data_writeReg
);

  mw_t mw;

  // Data memory port
  assign address_dmem = xm.result;
  assign wren = (xm.opcode == OP_SW);

  // Store right after the load of its data register
  // the loaded word only exists in writeback now
  assign data = (mw.we && (mw.rd == xm.rd)) ? data_writeReg : xm.store_data;

  // Forwarding taps for execute
  assign mem_rd = xm.rd;
  assign mem_we = xm.we;
  assign mem_result = (xm.opcode == OP_JAL) ? xm.pc_plus1 : xm.result;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mw <= '0;
    end else begin
      mw.rd        <= xm.rd;
      mw.we        <= xm.we;
      mw.is_load   <= (xm.opcode == OP_LW);
      mw.is_jal    <= (xm.opcode == OP_JAL);
      mw.result    <= xm.result;
      mw.load_data <= q_dmem;
      mw.pc_plus1  <= xm.pc_plus1;
    end
  end

  // Register file write port
  assign ctrl_writeEnable = mw.we;
  assign ctrl_writeReg = mw.rd;
  assign data_writeReg = mw.is_load ? mw.load_data :
                         mw.is_jal  ? mw.pc_plus1 : mw.result;

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module hazard_unit
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  reg_addr_t ex_rs,
  input  reg_addr_t ex_rt,
  input  logic      ex_is_load,
  input  reg_addr_t ex_rd,
  input  reg_addr_t mem_rd,
  input  logic      mem_we,
  input  reg_addr_t wb_rd,
  input  logic      wb_we,
  input  reg_addr_t dec_rs,
  input  reg_addr_t dec_rt,
  input  logic      dec_uses_rt,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b,
  output logic      stall
);

  // Youngest older writer wins, r0 stays hardwired
  function automatic fwd_sel_e select(reg_addr_t src, reg_addr_t m_rd, logic m_we,
                                      reg_addr_t w_rd, logic w_we);
    if (m_we && (m_rd != '0) && (m_rd == src)) begin
      select = FWD_MEM;
    end else if (w_we && (w_rd != '0) && (w_rd == src)) begin
      select = FWD_WB;
    end else begin
      select = FWD_NONE;
    end
  endfunction

  assign fwd_a = select(ex_rs, mem_rd, mem_we, wb_rd, wb_we);
  assign fwd_b = select(ex_rt, mem_rd, mem_we, wb_rd, wb_we);

  // Load data is not ready until memory, hold decode one cycle
  assign stall = ex_is_load && (ex_rd != '0) &&
                 ((dec_rs == ex_rd) || (dec_uses_rt && (dec_rt == ex_rd)));

endmodule

`default_nettype wire

// File: src/processor.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module processor
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  // Instruction memory
  output word_t     address_imem,
  input  word_t     q_imem,
  // Data memory
  output word_t     address_dmem,
  output word_t     data,
  output logic      wren,
  input  word_t     q_dmem,
  // Register file
  output logic      ctrl_writeEnable,
  output reg_addr_t ctrl_writeReg,
  output reg_addr_t ctrl_readRegA,
  output reg_addr_t ctrl_readRegB,
  output word_t     data_writeReg,
  input  word_t     data_readRegA,
  input  word_t     data_readRegB
);

  fd_t       fd;
  dx_t       dx;
  xm_t       xm;
  redirect_t redirect;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  logic      stall;
  logic      uses_rt;
  word_t     mem_result;
  reg_addr_t mem_rd;
  logic      mem_we;
  logic      ex_is_load;

  assign ex_is_load = (dx.opcode == OP_LW);

  fetch_stage u_fetch (
    .clock        (clock),
    .rst_n        (rst_n),
    .stall        (stall),
    .redirect     (redirect),
    .q_imem       (q_imem),
    .address_imem (address_imem),
    .fd           (fd)
  );

  decode_stage u_decode (
    .clock         (clock),
    .rst_n         (rst_n),
    .stall         (stall),
    .redirect      (redirect),
    .fd            (fd),
    .data_readRegA (data_readRegA),
    .data_readRegB (data_readRegB),
    .ctrl_readRegA (ctrl_readRegA),
    .ctrl_readRegB (ctrl_readRegB),
    .uses_rt       (uses_rt),
    .dx            (dx)
  );

  // Writeback forwarding taps straight off the register-file write port
  execute_stage u_execute (
    .clock      (clock),
    .rst_n      (rst_n),
    .dx         (dx),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (mem_result),
    .wb_result  (data_writeReg),
    .redirect   (redirect),
    .xm         (xm)
  );

  hazard_unit u_hazard (
    .ex_rs       (dx.rs),
    .ex_rt       (dx.rt),
    .ex_is_load  (ex_is_load),
    .ex_rd       (dx.rd),
    .mem_rd      (mem_rd),
    .mem_we      (mem_we),
    .wb_rd       (ctrl_writeReg),
    .wb_we       (ctrl_writeEnable),
    .dec_rs      (ctrl_readRegA),
    .dec_rt      (ctrl_readRegB),
    .dec_uses_rt (uses_rt),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .stall       (stall)
  );

  memory_writeback u_memwb (
    .clock            (clock),
    .rst_n            (rst_n),
    .xm               (xm),
    .q_dmem           (q_dmem),
    .address_dmem     (address_dmem),
    .data             (data),
    .wren             (wren),
    .mem_result       (mem_result),
    .mem_rd           (mem_rd),
    .mem_we           (mem_we),
    .ctrl_writeEnable (ctrl_writeEnable),
    .ctrl_writeReg    (ctrl_writeReg),
    .data_writeReg    (data_writeReg)
  );

endmodule

`default_nettype wire

// File: testbench/processor_sva.sv
`timescale 1ns/10ps
`default_nettype none

module processor_sva
  import isa_pkg::*;
(
  input logic      clock,
  input logic      rst_n,
  input logic      stall,
  input logic      redirect_taken,
  input logic      wren,
  input logic      ctrl_writeEnable,
  input reg_addr_t ctrl_writeReg,
  input word_t     address_imem
);

  // Never a register-file write aimed at r0
  a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
    ctrl_writeEnable |-> (ctrl_writeReg != '0))
    else $error("register write enabled with r0 as destination");

  // From the second reset edge on, all stage registers hold bubbles
  a_quiet_in_reset: assert property (@(posedge clock)
    (!rst_n ##1 !rst_n) |-> (!wren && !ctrl_writeEnable))
    else $error("write port active while reset is asserted");

  // Load-use hold keeps the fetch address
  a_pc_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (stall && !redirect_taken) |=> $stable(address_imem))
    else $error("fetch address moved during a load-use stall");

endmodule

bind processor processor_sva u_sva (
  .clock            (clock),
  .rst_n            (rst_n),
  .stall            (stall),
  .redirect_taken   (redirect.taken),
  .wren             (wren),
  .ctrl_writeEnable (ctrl_writeEnable),
  .ctrl_writeReg    (ctrl_writeReg),
  .address_imem     (address_imem)
);

`default_nettype wire

// File: testbench/processor_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module processor_tb
  import isa_pkg::*;
();

  localparam int PROG_WORDS   = 64;
  localparam int DMEM_WORDS   = 64;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_TIMEOUT  = 2000;
  localparam int MODEL_STEPS  = 256;

  logic      clock;
  logic      rst_n;
  word_t     address_imem;
  word_t     q_imem;
  word_t     address_dmem;
  word_t     data;
  logic      wren;
  word_t     q_dmem;
  logic      ctrl_writeEnable;
  reg_addr_t ctrl_writeReg;
  reg_addr_t ctrl_readRegA;
  reg_addr_t ctrl_readRegB;
  word_t     data_writeReg;
  word_t     data_readRegA;
  word_t     data_readRegB;

  // External memories and register file
  word_t imem [PROG_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t regs [32];

  // Expected register writes and stores, in program order
  reg_addr_t exp_rd_q [$];
  word_t     exp_val_q [$];
  word_t     exp_addr_q [$];
  word_t     exp_data_q [$];

  logic [15:0] lfsr_state;
  int mismatch_count;
  int other_count;
  int reg_writes;
  int store_writes;

  processor u_dut (
    .clock            (clock),
    .rst_n            (rst_n),
    .address_imem     (address_imem),
    .q_imem           (q_imem),
    .address_dmem     (address_dmem),
    .data             (data),
    .wren             (wren),
    .q_dmem           (q_dmem),
    .ctrl_writeEnable (ctrl_writeEnable),
    .ctrl_writeReg    (ctrl_writeReg),
    .ctrl_readRegA    (ctrl_readRegA),
    .ctrl_readRegB    (ctrl_readRegB),
    .data_writeReg    (data_writeReg),
    .data_readRegA    (data_readRegA),
    .data_readRegB    (data_readRegB)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Fetches past the program see add r0, which writes nothing
  assign q_imem = (address_imem < PROG_WORDS) ? imem[address_imem[5:0]] : '0;
  assign q_dmem = dmem[address_dmem[5:0]];

  // Combinational reads with write-through of the port being written
  assign data_readRegA = (ctrl_writeEnable && (ctrl_writeReg != '0) &&
                          (ctrl_writeReg == ctrl_readRegA)) ?
                         data_writeReg : regs[ctrl_readRegA];
  assign data_readRegB = (ctrl_writeEnable && (ctrl_writeReg != '0) &&
                          (ctrl_writeReg == ctrl_readRegB)) ?
                         data_writeReg : regs[ctrl_readRegB];

  always @(posedge clock) begin
    if (ctrl_writeEnable && (ctrl_writeReg != '0)) begin
      regs[ctrl_writeReg] <= data_writeReg;
    end
    if (wren) begin
      dmem[address_dmem[5:0]] <= data;
    end
  end

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic word_t random_bits(input int n);
    word_t v;
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[`CPU_XLEN-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Small register set so dependencies are frequent
  function automatic reg_addr_t random_reg();
    return reg_addr_t'(random_bits(3));
  endfunction

  function automatic word_t alu_instr(alu_op_e op, reg_addr_t rd, reg_addr_t rs,
                                      reg_addr_t rt, reg_addr_t shamt);
    return {OP_ALU, rd, rs, rt, shamt, op, 2'b00};
  endfunction

  function automatic word_t imm_instr(opcode_e opc, reg_addr_t rd, reg_addr_t rs,
                                      logic [`CPU_IMM_W-1:0] imm);
    return {opc, rd, rs, imm};
  endfunction

  function automatic word_t jump_instr(opcode_e opc, logic [`CPU_TGT_W-1:0] tgt);
    return {opc, tgt};
  endfunction

  // Random program with forward-only control flow, ending in j to itself
  task automatic build_program();
    logic is_target [PROG_WORDS];
    int i;
    int kind;
    int skip;
    reg_addr_t ra;
    reg_addr_t rb;
    for (i = 0; i < PROG_WORDS; i++) begin
      is_target[i] = 1'b0;
    end
    i = 0;
    while (i < PROG_WORDS - 1) begin
      kind = int'(random_bits(4));
      skip = int'(random_bits(2)) + 1;
      ra = random_reg();
      rb = random_reg();
      if (i + 1 + skip > PROG_WORDS - 1) begin
        skip = PROG_WORDS - 2 - i;
      end
      // Pairs need two free words
      if ((kind == 11 || kind == 14 || kind == 15) && (i > PROG_WORDS - 3)) begin
        kind = 5;
      end
      // A jr must only be reached through its own addi
      if (kind == 14 && is_target[i + 1]) begin
        kind = 5;
      end
      if (kind <= 4) begin
        imem[i] = alu_instr(alu_op_e'(5'(random_bits(3) % 6)), ra, rb, random_reg(),
                            reg_addr_t'(random_bits(5)));
        i++;
      end else if (kind <= 7) begin
        imem[i] = imm_instr(OP_ADDI, ra, rb, 17'(random_bits(17)));
        i++;
      end else if (kind <= 9) begin
        imem[i] = imm_instr(OP_LW, ra, '0, 17'(random_bits(6)));
        i++;
      end else if (kind == 10) begin
        imem[i] = imm_instr(OP_SW, ra, '0, 17'(random_bits(6)));
        i++;
      end else if (kind == 11) begin
        // Store of the register loaded just before
        imem[i] = imm_instr(OP_LW, ra, '0, 17'(random_bits(6)));
        imem[i + 1] = imm_instr(OP_SW, ra, '0, 17'(random_bits(6)));
        i += 2;
      end else if (kind == 12) begin
        imem[i] = imm_instr((random_bits(1) == 1) ? OP_BLT : OP_BNE, ra, rb, 17'(skip));
        is_target[i + 1 + skip] = 1'b1;
        i++;
      end else if (kind == 13) begin
        imem[i] = jump_instr((random_bits(1) == 1) ? OP_JAL : OP_J, 27'(i + 1 + skip));
        is_target[i + 1 + skip] = 1'b1;
        i++;
      end else if (kind == 14) begin
        if (i + 2 + skip > PROG_WORDS - 1) begin
          skip = PROG_WORDS - 3 - i;
        end
        ra = (ra == '0) ? reg_addr_t'(1) : ra;
        imem[i] = imm_instr(OP_ADDI, ra, '0, 17'(i + 2 + skip));
        imem[i + 1] = imm_instr(OP_JR, ra, '0, '0);
        is_target[i + 2 + skip] = 1'b1;
        i += 2;
      end else begin
        // Load-use pair
        imem[i] = imm_instr(OP_LW, ra, '0, 17'(random_bits(6)));
        imem[i + 1] = alu_instr(ADD, rb, ra, random_reg(), '0);
        i += 2;
      end
    end
    imem[PROG_WORDS - 1] = jump_instr(OP_J, 27'(PROG_WORDS - 1));
  endtask

  // Sequential ISA model, fills the expected queues
  task automatic run_model();
    word_t r [32];
    word_t mem [DMEM_WORDS];
    word_t ins;
    word_t pc;
    word_t next_pc;
    word_t va;
    word_t vb;
    word_t vd;
    word_t imm;
    word_t res;
    reg_addr_t dest;
    logic wr;
    int steps;
    for (steps = 0; steps < 32; steps++) begin
      r[steps] = '0;
    end
    for (steps = 0; steps < DMEM_WORDS; steps++) begin
      mem[steps] = dmem[steps];
    end
    pc = '0;
    steps = 0;
    while ((pc < PROG_WORDS - 1) && (steps < MODEL_STEPS)) begin
      ins = imem[pc[5:0]];
      vd = r[ins[26:22]];
      va = r[ins[21:17]];
      vb = r[ins[16:12]];
      imm = {{(`CPU_XLEN - `CPU_IMM_W){ins[16]}}, ins[16:0]};
      next_pc = pc + 1;
      dest = ins[26:22];
      wr = 1'b0;
      res = '0;
      case (opcode_e'(ins[31:27]))
        OP_ALU: begin
          wr = 1'b1;
          case (alu_op_e'(ins[6:2]))
            ADD: res = va + vb;
            SUB: res = va - vb;
            AND: res = va & vb;
            OR:  res = va | vb;
            SLL: res = va << ins[11:7];
            SRA: res = word_t'($signed(va) >>> ins[11:7]);
            default: res = '0;
          endcase
        end
        OP_ADDI: begin
          wr = 1'b1;
          res = va + imm;
        end
        OP_LW: begin
          wr = 1'b1;
          res = mem[(va + imm) % DMEM_WORDS];
        end
        OP_SW: begin
          mem[(va + imm) % DMEM_WORDS] = vd;
          exp_addr_q.push_back(va + imm);
          exp_data_q.push_back(vd);
        end
        OP_BNE: if (vd != va) next_pc = pc + 1 + imm;
        OP_BLT: if ($signed(vd) < $signed(va)) next_pc = pc + 1 + imm;
        OP_J:   next_pc = word_t'(ins[26:0]);
        OP_JAL: begin
          wr = 1'b1;
          dest = reg_addr_t'(`CPU_LINK_REG);
          res = pc + 1;
          next_pc = word_t'(ins[26:0]);
        end
        OP_JR:  next_pc = vd;
        default: ;
      endcase
      if (wr && (dest != '0)) begin
        r[dest] = res;
        exp_rd_q.push_back(dest);
        exp_val_q.push_back(res);
      end
      pc = next_pc;
      steps++;
    end
    if (pc != PROG_WORDS - 1) begin
      other_count++;
      $display("ERROR: model never reached the final jump, stopped at pc %0d", pc);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t expected,
                           input reg_addr_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  // Port monitor, mid-cycle when writeback and memory outputs are settled
  always @(negedge clock) begin
    if (!rst_n) begin
      if ((wren === 1'b1) || (ctrl_writeEnable === 1'b1)) begin
        other_count++;
        $display("ERROR: write port active while reset is asserted");
      end
    end else begin
      if (ctrl_writeEnable) begin
        if (ctrl_writeReg == '0) begin
          other_count++;
          $display("ERROR: register write to r0 appeared at the port");
        end else if (exp_rd_q.size() == 0) begin
          other_count++;
          $display("ERROR: register write to r%0d that the model never made", ctrl_writeReg);
        end else begin
          check_reg($sformatf("reg write %0d number", reg_writes), exp_rd_q.pop_front(),
                    ctrl_writeReg);
          check_word($sformatf("reg write %0d data", reg_writes), exp_val_q.pop_front(),
                     data_writeReg);
          reg_writes++;
        end
      end
      if (wren) begin
        if (exp_addr_q.size() == 0) begin
          other_count++;
          $display("ERROR: store to %08h that the model never made", address_dmem);
        end else begin
          check_word($sformatf("store %0d address", store_writes), exp_addr_q.pop_front(),
                     address_dmem);
          check_word($sformatf("store %0d data", store_writes), exp_data_q.pop_front(), data);
          store_writes++;
        end
      end
    end
  end

  initial begin
    int i;
    int cycles;
    rst_n = 1'b0;
    lfsr_state = 16'd89;
    mismatch_count = 0;
    other_count = 0;
    reg_writes = 0;
    store_writes = 0;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = random_bits(`CPU_XLEN);
    end
    build_program();
    run_model();
    $display("Model expects %0d register writes and %0d stores",
             exp_rd_q.size(), exp_addr_q.size());
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    rst_n = 1'b1;
    // Run until every expected write has been seen
    cycles = 0;
    while (((exp_rd_q.size() != 0) || (exp_addr_q.size() != 0)) && (cycles < RUN_TIMEOUT)) begin
      @(posedge clock);
      cycles++;
    end
    if ((exp_rd_q.size() != 0) || (exp_addr_q.size() != 0)) begin
      other_count++;
      $display("ERROR: timeout with %0d register writes and %0d stores still missing",
               exp_rd_q.size(), exp_addr_q.size());
    end
    // Final j loop must stay silent
    repeat (20) @(posedge clock);
    $display("Errors: %0d value mismatches, %0d other failures, %0d writes and %0d stores seen",
             mismatch_count, other_count, reg_writes, store_writes);
    if ((mismatch_count == 0) && (other_count == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/memory_writeback.sv
src/hazard_unit.sv
src/processor.sv
testbench/processor_sva.sv
testbench/processor_tb.sv
